// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module ise_tb -o ise_tb_sim \
    && ./obj_dir/ise_tb_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

// ==== src.f ====
+incdir+include
verilog/ise_isa_pkg.sv
verilog/ise_core_pkg.sv
verilog/ise_decoder.sv
verilog/ise_cpr_file.sv
verilog/ise_exec_unit.sv
verilog/ise_top.sv
verification/ise_tb.sv

// ==== include/ise_tb_checks.svh ====
`ifndef ISE_TB_CHECKS_SVH
`define ISE_TB_CHECKS_SVH

// Running tallies for the final report
int n_pass = 0;
int n_fail = 0;

// --------------------------------------------------
// Instruction encoders
// --------------------------------------------------

// Register form, dst goes in the RD/CRD slot
function automatic ise_core_pkg::word_t enc_reg(input logic [3:0] funct,
                                                input ise_core_pkg::gpr_idx_t dst,
                                                input ise_core_pkg::cpr_idx_t crs1,
                                                input ise_core_pkg::cpr_idx_t crs2,
                                                input ise_core_pkg::lut_t lut4);
    ise_core_pkg::word_t w;
    w = '0;
    w[6:0] = ise_isa_pkg::ISE_OPCODE;
    w[ise_isa_pkg::FUNCT_LSB +: 4] = funct;
    w[ise_isa_pkg::RD_LSB    +: 5] = dst;
    w[ise_isa_pkg::CRS1_LSB  +: 4] = crs1;
    w[ise_isa_pkg::CRS2_LSB  +: 4] = crs2;
    w[ise_isa_pkg::LUT4_LSB  +: 4] = lut4;
    return w;
endfunction

// Immediate form for lui.cr and lli.cr
function automatic ise_core_pkg::word_t enc_imm(input logic [3:0] funct,
                                                input ise_core_pkg::cpr_idx_t crd,
                                                input ise_core_pkg::imm_t imm16);
    ise_core_pkg::word_t w;
    w = '0;
    w[6:0] = ise_isa_pkg::ISE_OPCODE;
    w[ise_isa_pkg::FUNCT_LSB +: 4]  = funct;
    w[ise_isa_pkg::CRD_LSB   +: 4]  = crd;
    w[ise_isa_pkg::IMM16_LSB +: 16] = imm16;
    return w;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------

task automatic check_bits(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        n_fail++;
    end
    else
    begin
        n_pass++;
    end
endtask

task automatic check_word(input string name, input ise_core_pkg::word_t exp,
                          input ise_core_pkg::word_t act);
    check_bits(name, exp, act);
endtask

task automatic check_result(input string name, input ise_core_pkg::result_t exp,
                            input ise_core_pkg::result_t act);
    check_bits(name, 32'(exp), 32'(act));
endtask

task automatic check_mask(input string name, input ise_core_pkg::cpr_mask_t exp,
                          input ise_core_pkg::cpr_mask_t act);
    check_bits(name, 32'(exp), 32'(act));
endtask

task automatic check_gpr(input string name, input ise_core_pkg::gpr_idx_t exp,
                         input ise_core_pkg::gpr_idx_t act);
    check_bits(name, 32'(exp), 32'(act));
endtask

`endif

// ==== verification/ise_tb.sv ====
`timescale 1ns/1ps

module ise_tb;

    logic                    g_clk;
    logic                    g_resetn;
    logic                    cop_insn_valid;
    ise_core_pkg::word_t     cop_insn_enc;
    ise_core_pkg::word_t     cop_rs1;
    logic                    cop_result_valid;
    ise_core_pkg::result_t   cop_result;
    ise_core_pkg::cpr_mask_t cop_cprs_read;
    ise_core_pkg::cpr_mask_t cop_cprs_written;
    logic                    cop_rd_wen;
    ise_core_pkg::gpr_idx_t  cop_rd_addr;
    ise_core_pkg::word_t     cop_rd_data;

    integer              seed = 77838;  // Fixed seed for $random
    ise_core_pkg::word_t model [16];    // Expected CPR contents

    `include "ise_tb_checks.svh"

    ise_top dut_i (
        .g_clk            (g_clk),
        .g_resetn         (g_resetn),
        .cop_insn_valid   (cop_insn_valid),
        .cop_insn_enc     (cop_insn_enc),
        .cop_rs1          (cop_rs1),
        .cop_result_valid (cop_result_valid),
        .cop_result       (cop_result),
        .cop_cprs_read    (cop_cprs_read),
        .cop_cprs_written (cop_cprs_written),
        .cop_rd_wen       (cop_rd_wen),
        .cop_rd_addr      (cop_rd_addr),
        .cop_rd_data      (cop_rd_data)
    );

    initial
    begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk; // 8 ns period
    end

    // --------------------------------------------------
    // Drive and wait helpers
    // --------------------------------------------------

    function automatic ise_core_pkg::cpr_mask_t one_hot(input ise_core_pkg::cpr_idx_t n);
        ise_core_pkg::cpr_mask_t m;
        m    = '0;
        m[n] = 1'b1;
        return m;
    endfunction

    // Bit i of the result is LUT entry number 2*crs1[i] + crs2[i]
    function automatic ise_core_pkg::word_t bop_expect(input ise_core_pkg::lut_t lut,
                                                       input ise_core_pkg::word_t a,
                                                       input ise_core_pkg::word_t b);
        ise_core_pkg::word_t w;
        logic [1:0]          sel;
        for (int i = 0; i < ise_core_pkg::XLEN; i++)
        begin
            sel  = {a[i], b[i]};
            w[i] = lut[sel];
        end
        return w;
    endfunction

    task automatic drive_insn(input ise_core_pkg::word_t enc, input ise_core_pkg::word_t rs1);
        cop_insn_valid = 1'b1;
        cop_insn_enc   = enc;
        cop_rs1        = rs1;
    endtask

    task automatic drive_idle();
        cop_insn_valid = 1'b0;
        cop_insn_enc   = '0;
        cop_rs1        = '0;
    endtask

    // One-cycle strobe, returns 1 ns after the sampling edge
    task automatic issue(input ise_core_pkg::word_t enc, input ise_core_pkg::word_t rs1);
        drive_insn(enc, rs1);
        @(posedge g_clk);
        #1;
        drive_idle();
    endtask

    task automatic wait_result(output bit ok);
        int cycles;
        cycles = 0;
        while (!cop_result_valid && cycles < 20)
        begin
            @(posedge g_clk);
            #1;
            cycles++;
        end
        ok = cop_result_valid;
        if (!ok)
        begin
            $display("Error at %0t: no result strobe within timeout", $time);
            n_fail++;
        end
    endtask

    task automatic check_outputs(input ise_core_pkg::result_t   exp_res,
                                 input ise_core_pkg::cpr_mask_t exp_rmask,
                                 input ise_core_pkg::cpr_mask_t exp_wmask,
                                 input logic                    exp_rd_wen,
                                 input ise_core_pkg::gpr_idx_t  exp_rd_addr,
                                 input ise_core_pkg::word_t     exp_rd_data);
        check_result("cop_result", exp_res, cop_result);
        check_mask("cop_cprs_read", exp_rmask, cop_cprs_read);
        check_mask("cop_cprs_written", exp_wmask, cop_cprs_written);
        check_bits("cop_rd_wen", 32'(exp_rd_wen), 32'(cop_rd_wen));
        if (exp_rd_wen)
        begin
            check_gpr("cop_rd_addr", exp_rd_addr, cop_rd_addr);   // Only meaningful with wen
            check_word("cop_rd_data", exp_rd_data, cop_rd_data);
        end
    endtask

    task automatic exec_and_check(input ise_core_pkg::word_t     enc,
                                  input ise_core_pkg::word_t     rs1,
                                  input ise_core_pkg::result_t   exp_res,
                                  input ise_core_pkg::cpr_mask_t exp_rmask,
                                  input ise_core_pkg::cpr_mask_t exp_wmask,
                                  input logic                    exp_rd_wen,
                                  input ise_core_pkg::gpr_idx_t  exp_rd_addr,
                                  input ise_core_pkg::word_t     exp_rd_data);
        bit ok;
        issue(enc, rs1);
        wait_result(ok);
        if (ok)
        begin
            check_outputs(exp_res, exp_rmask, exp_wmask, exp_rd_wen, exp_rd_addr, exp_rd_data);
        end
    endtask

    // mv2cop, updates the model
    task automatic write_cpr(input ise_core_pkg::cpr_idx_t idx, input ise_core_pkg::word_t v);
        exec_and_check(enc_reg(ise_isa_pkg::FUNCT_MV2COP, {1'b0, idx}, 4'd0, 4'd0, 4'd0), v,
                       ise_core_pkg::RESULT_SUCCESS, '0, one_hot(idx), 1'b0, '0, '0);
        model[idx] = v;
    endtask

    // mv2gpr into GPR 16+idx, checked against the model
    task automatic read_cpr(input ise_core_pkg::cpr_idx_t idx);
        ise_core_pkg::gpr_idx_t rd;
        rd = {1'b1, idx};
        exec_and_check(enc_reg(ise_isa_pkg::FUNCT_MV2GPR, rd, idx, 4'd0, 4'd0), '0,
                       ise_core_pkg::RESULT_SUCCESS, one_hot(idx), '0, 1'b1, rd, model[idx]);
    endtask

    task automatic report_test(input string name, input int fails_at_start);
        if (n_fail == fails_at_start)
        begin
            $display("%-24s ok", name);
        end
        else
        begin
            $display("%-24s FAILED, %0d bad checks", name, n_fail - fails_at_start);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset_and_moves();
        int f0;
        f0 = n_fail;
        check_bits("cop_result_valid", 32'd0, 32'(cop_result_valid)); // Straight out of reset
        check_bits("cop_rd_wen", 32'd0, 32'(cop_rd_wen));
        for (int n = 0; n < 16; n++)
        begin
            write_cpr(n[3:0], $random(seed));
        end
        for (int n = 0; n < 16; n++)
        begin
            read_cpr(n[3:0]);
        end
        report_test("reset and move", f0);
    endtask

    task automatic test_forwarding();
        int                     f0;
        bit                     ok;
        ise_core_pkg::cpr_idx_t idx;
        ise_core_pkg::word_t    v;
        f0 = n_fail;
        for (int n = 3; n < 16; n += 5)
        begin
            idx = n[3:0];
            v   = $random(seed);
            drive_insn(enc_reg(ise_isa_pkg::FUNCT_MV2COP, {1'b0, idx}, 4'd0, 4'd0, 4'd0), v);
            @(posedge g_clk);
            #1;
            drive_insn(enc_reg(ise_isa_pkg::FUNCT_MV2GPR, 5'd5, idx, 4'd0, 4'd0), '0);
            @(posedge g_clk);
            #1;
            drive_idle();
            wait_result(ok);
            if (ok)
            begin
                check_outputs(ise_core_pkg::RESULT_SUCCESS, '0, one_hot(idx), 1'b0, '0, '0);
                @(posedge g_clk);
                #1;
                if (!cop_result_valid)
                begin
                    $display("Error at %0t: second result did not follow on the next cycle",
                             $time);
                    n_fail++;
                end
                else
                begin
                    // New value must come through the bypass
                    check_outputs(ise_core_pkg::RESULT_SUCCESS, one_hot(idx), '0, 1'b1, 5'd5, v);
                end
            end
            model[idx] = v;
        end
        report_test("back-to-back forwarding", f0);
    endtask

    task automatic test_cond_moves();
        int                  f0;
        bit                  negate;
        bit                  move;
        ise_core_pkg::word_t a;
        ise_core_pkg::word_t b;
        ise_core_pkg::word_t d;
        f0 = n_fail;
        for (int c = 0; c < 4; c++)
        begin
            negate = c[1];                      // cmovn on the upper two passes
            a      = $random(seed);
            b      = $random(seed);
            d      = $random(seed);
            b      = c[0] ? 32'h0 : (b | 32'h1); // Zero or surely non-zero
            write_cpr(4'd1, a);
            write_cpr(4'd2, b);
            write_cpr(4'd3, d);
            move = negate ? (b != 32'h0) : (b == 32'h0);
            exec_and_check(enc_reg(negate ? ise_isa_pkg::FUNCT_CMOVN : ise_isa_pkg::FUNCT_CMOV,
                                   5'd3, 4'd1, 4'd2, 4'd0), '0,
                           ise_core_pkg::RESULT_SUCCESS, one_hot(4'd1) | one_hot(4'd2),
                           move ? one_hot(4'd3) : '0, 1'b0, '0, '0);
            if (move)
            begin
                model[3] = a;
            end
            read_cpr(4'd3);
        end
        report_test("conditional moves", f0);
    endtask

    task automatic test_bitwise();
        int                  f0;
        ise_core_pkg::word_t a;
        ise_core_pkg::word_t b;
        f0 = n_fail;
        for (int n = 0; n < 16; n++)
        begin
            a = $random(seed);
            b = $random(seed);
            write_cpr(4'd4, a);
            write_cpr(4'd5, b);
            exec_and_check(enc_reg(ise_isa_pkg::FUNCT_BOP, 5'd6, 4'd4, 4'd5, n[3:0]), '0,
                           ise_core_pkg::RESULT_SUCCESS, one_hot(4'd4) | one_hot(4'd5),
                           one_hot(4'd6), 1'b0, '0, '0);
            model[6] = bop_expect(n[3:0], a, b);
            read_cpr(4'd6);
        end
        report_test("bitwise op", f0);
    endtask

    task automatic test_immediates();
        int                  f0;
        ise_core_pkg::word_t r;
        f0 = n_fail;
        write_cpr(4'd7, $random(seed));
        r = $random(seed);
        exec_and_check(enc_imm(ise_isa_pkg::FUNCT_LUI, 4'd7, r[15:0]), '0,
                       ise_core_pkg::RESULT_SUCCESS, one_hot(4'd7), one_hot(4'd7), 1'b0, '0, '0);
        model[7][31:16] = r[15:0];              // Upper half replaced
        read_cpr(4'd7);
        r = $random(seed);
        exec_and_check(enc_imm(ise_isa_pkg::FUNCT_LLI, 4'd7, r[15:0]), '0,
                       ise_core_pkg::RESULT_SUCCESS, one_hot(4'd7), one_hot(4'd7), 1'b0, '0, '0);
        model[7][15:0] = r[15:0];
        read_cpr(4'd7);
        report_test("immediate loads", f0);
    endtask

    task automatic test_decode_exception();
        int                  f0;
        ise_core_pkg::word_t enc;
        f0 = n_fail;
        write_cpr(4'd8, $random(seed));
        enc      = enc_reg(ise_isa_pkg::FUNCT_MV2COP, 5'd8, 4'd0, 4'd0, 4'd0);
        enc[6:0] = ise_isa_pkg::ISE_OPCODE ^ 7'h04; // Wrong major opcode
        exec_and_check(enc, $random(seed), ise_core_pkg::RESULT_DECODE_EXCEPTION,
                       '0, '0, 1'b0, '0, '0);
        exec_and_check(enc_reg(4'd9, 5'd8, 4'd0, 4'd0, 4'd0), $random(seed),
                       ise_core_pkg::RESULT_DECODE_EXCEPTION, '0, '0, 1'b0, '0, '0);
        read_cpr(4'd8);                           // Target left as it was
        report_test("decode exception", f0);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial
    begin
        g_resetn = 1'b0;
        drive_idle();
        repeat (3) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;

        test_reset_and_moves();
        test_forwarding();
        test_cond_moves();
        test_bitwise();
        test_immediates();
        test_decode_exception();

        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/ise_core_pkg.sv ====
package ise_core_pkg;

    localparam int XLEN      = 32;
    localparam int CPR_COUNT = 16;

    // --------------------------------------------------
    // Datapath types
    // --------------------------------------------------

    typedef logic [XLEN-1:0]      word_t;     // Data word
    typedef logic [3:0]           cpr_idx_t;  // CPR index
    typedef logic [4:0]           gpr_idx_t;  // GPR index
    typedef logic [CPR_COUNT-1:0] cpr_mask_t; // One bit per CPR
    typedef logic [3:0]           lut_t;      // bop.cr truth table
    typedef logic [15:0]          imm_t;      // lui/lli immediate

    // Decoded operation
    typedef enum logic [3:0] {
        OP_NONE,    // No instruction this cycle
        OP_MV2GPR,
        OP_MV2COP,
        OP_CMOV,
        OP_CMOVN,
        OP_BOP,
        OP_LUI,
        OP_LLI,
        OP_INVALID  // Bad major opcode or function code
    } ise_op_t;

    // --------------------------------------------------
    // Result codes
    // --------------------------------------------------

    typedef logic [2:0] result_t;

    localparam result_t RESULT_SUCCESS          = 3'd0;
    localparam result_t RESULT_DECODE_EXCEPTION = 3'd2;

endpackage

// ==== verilog/ise_cpr_file.sv ====
`timescale 1ns/1ps

module ise_cpr_file (
    input  logic                   g_clk,
    input  ise_core_pkg::cpr_idx_t rd_addr_a, // CRS1 port
    input  ise_core_pkg::cpr_idx_t rd_addr_b, // CRS2 port
    input  ise_core_pkg::cpr_idx_t rd_addr_c, // CRD port
    output ise_core_pkg::word_t    rd_data_a,
    output ise_core_pkg::word_t    rd_data_b,
    output ise_core_pkg::word_t    rd_data_c,
    input  logic                   wen,       // Write from stage two
    input  ise_core_pkg::cpr_idx_t waddr,
    input  ise_core_pkg::word_t    wdata
);

    // CPR storage, architectural state set up by software
    ise_core_pkg::word_t cprs [ise_core_pkg::CPR_COUNT];

    logic hit_a;
    logic hit_b;
    logic hit_c;

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------

    always_ff @(posedge g_clk)
    begin
        if (wen)
        begin
            cprs[waddr] <= wdata;
        end
    end

    // --------------------------------------------------
    // Read ports with write-through
    // --------------------------------------------------

    // Stage one sees the value stage two is about to commit
    assign hit_a = wen && (waddr == rd_addr_a);
    assign hit_b = wen && (waddr == rd_addr_b);
    assign hit_c = wen && (waddr == rd_addr_c);

    assign rd_data_a = hit_a ? wdata : cprs[rd_addr_a];
    assign rd_data_b = hit_b ? wdata : cprs[rd_addr_b];
    assign rd_data_c = hit_c ? wdata : cprs[rd_addr_c];

endmodule

// ==== verilog/ise_decoder.sv ====
`timescale 1ns/1ps

module ise_decoder (
    input  logic                   insn_valid, // Instruction strobe
    input  ise_core_pkg::word_t    insn_enc,   // Encoded instruction
    output ise_core_pkg::ise_op_t  op,         // Decoded operation
    output ise_core_pkg::cpr_idx_t crd,
    output ise_core_pkg::cpr_idx_t crs1,
    output ise_core_pkg::cpr_idx_t crs2,
    output ise_core_pkg::gpr_idx_t rd,
    output ise_core_pkg::lut_t     lut4,
    output ise_core_pkg::imm_t     imm16,
    output logic                   reads_crs1, // Operation reads CRS1
    output logic                   reads_crs2, // Operation reads CRS2
    output logic                   reads_crd   // Operation reads CRD
);

    logic [6:0] major;
    logic [3:0] funct;

    assign major = insn_enc[6:0];
    assign funct = insn_enc[ise_isa_pkg::FUNCT_LSB +: 4];

    // Plain field slices, meaningful only for the ops that use them
    assign crd   = insn_enc[ise_isa_pkg::CRD_LSB   +: 4];
    assign rd    = insn_enc[ise_isa_pkg::RD_LSB    +: 5];
    assign crs1  = insn_enc[ise_isa_pkg::CRS1_LSB  +: 4];
    assign crs2  = insn_enc[ise_isa_pkg::CRS2_LSB  +: 4];
    assign lut4  = insn_enc[ise_isa_pkg::LUT4_LSB  +: 4];
    assign imm16 = insn_enc[ise_isa_pkg::IMM16_LSB +: 16];

    // --------------------------------------------------
    // Opcode and function code check
    // --------------------------------------------------

    always_comb
    begin
        op = ise_core_pkg::OP_NONE;
        if (insn_valid)
        begin
            if (major != ise_isa_pkg::ISE_OPCODE)
            begin
                op = ise_core_pkg::OP_INVALID; // Not our major opcode
            end
            else
            begin
                case (funct)
                    ise_isa_pkg::FUNCT_MV2GPR: op = ise_core_pkg::OP_MV2GPR;
                    ise_isa_pkg::FUNCT_MV2COP: op = ise_core_pkg::OP_MV2COP;
                    ise_isa_pkg::FUNCT_CMOV:   op = ise_core_pkg::OP_CMOV;
                    ise_isa_pkg::FUNCT_CMOVN:  op = ise_core_pkg::OP_CMOVN;
                    ise_isa_pkg::FUNCT_BOP:    op = ise_core_pkg::OP_BOP;
                    ise_isa_pkg::FUNCT_LUI:    op = ise_core_pkg::OP_LUI;
                    ise_isa_pkg::FUNCT_LLI:    op = ise_core_pkg::OP_LLI;
                    default:                   op = ise_core_pkg::OP_INVALID;
                endcase
            end
        end
    end

    // CPR read usage, feeds the read mask
    assign reads_crs1 = (op == ise_core_pkg::OP_MV2GPR) || (op == ise_core_pkg::OP_CMOV) ||
                        (op == ise_core_pkg::OP_CMOVN)  || (op == ise_core_pkg::OP_BOP);
    assign reads_crs2 = (op == ise_core_pkg::OP_CMOV) || (op == ise_core_pkg::OP_CMOVN) ||
                        (op == ise_core_pkg::OP_BOP);
    // lui/lli keep half of the old value
    assign reads_crd  = (op == ise_core_pkg::OP_LUI) || (op == ise_core_pkg::OP_LLI);

endmodule

// ==== verilog/ise_exec_unit.sv ====
`timescale 1ns/1ps

module ise_exec_unit (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  ise_core_pkg::ise_op_t     op,
    input  ise_core_pkg::cpr_idx_t    crd,
    input  ise_core_pkg::cpr_idx_t    crs1,
    input  ise_core_pkg::cpr_idx_t    crs2,
    input  ise_core_pkg::gpr_idx_t    rd,
    input  ise_core_pkg::lut_t        lut4,
    input  ise_core_pkg::imm_t        imm16,
    input  logic                      reads_crs1,
    input  logic                      reads_crs2,
    input  logic                      reads_crd,
    input  ise_core_pkg::word_t       rs1_data,     // GPR operand
    input  ise_core_pkg::word_t       crs1_data,
    input  ise_core_pkg::word_t       crs2_data,
    input  ise_core_pkg::word_t       crd_data,
    output logic                      cpr_wen,      // CPR write port
    output ise_core_pkg::cpr_idx_t    cpr_waddr,
    output ise_core_pkg::word_t       cpr_wdata,
    output logic                      result_valid, // One-cycle pulse
    output ise_core_pkg::result_t     result,
    output ise_core_pkg::cpr_mask_t   cprs_read,
    output ise_core_pkg::cpr_mask_t   cprs_written,
    output logic                      rd_wen,       // GPR write-back
    output ise_core_pkg::gpr_idx_t    rd_addr,
    output ise_core_pkg::word_t       rd_data
);

    // --------------------------------------------------
    // Stage two registers
    // --------------------------------------------------

    logic                   s2_valid;
    ise_core_pkg::ise_op_t  s2_op;
    ise_core_pkg::cpr_idx_t s2_crd, s2_crs1, s2_crs2;
    ise_core_pkg::gpr_idx_t s2_rd;
    ise_core_pkg::lut_t     s2_lut4;
    ise_core_pkg::imm_t     s2_imm16;
    logic                   s2_reads_crs1, s2_reads_crs2, s2_reads_crd;
    ise_core_pkg::word_t    s2_rs1, s2_crs1_data, s2_crs2_data, s2_crd_data;

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            s2_valid <= 1'b0;
        end
        else
        begin
            s2_valid <= (op != ise_core_pkg::OP_NONE);
        end
    end

    always_ff @(posedge g_clk)
    begin
        s2_op         <= op;
        s2_crd        <= crd;
        s2_crs1       <= crs1;
        s2_crs2       <= crs2;
        s2_rd         <= rd;
        s2_lut4       <= lut4;
        s2_imm16      <= imm16;
        s2_reads_crs1 <= reads_crs1;
        s2_reads_crs2 <= reads_crs2;
        s2_reads_crd  <= reads_crd;
        s2_rs1        <= rs1_data;
        s2_crs1_data  <= crs1_data;
        s2_crs2_data  <= crs2_data;
        s2_crd_data   <= crd_data;
    end

    // --------------------------------------------------
    // Execute
    // --------------------------------------------------

    ise_core_pkg::word_t       bop_val;   // Bitwise LUT result
    ise_core_pkg::word_t       wr_val;
    logic                      wr_cond;   // Op wants a CPR write
    logic                      gpr_cond;  // Op wants a GPR write
    ise_core_pkg::cpr_mask_t   rmask;
    ise_core_pkg::cpr_mask_t   wmask;

    // Bit i picks lut4 entry {crs1[i], crs2[i]}
    always_comb
    begin
        for (int i = 0; i < ise_core_pkg::XLEN; i++)
        begin
            bop_val[i] = s2_lut4[{s2_crs1_data[i], s2_crs2_data[i]}];
        end
    end

    always_comb
    begin
        wr_val   = s2_crs1_data;
        wr_cond  = 1'b0;
        gpr_cond = 1'b0;
        case (s2_op)
            ise_core_pkg::OP_MV2GPR: gpr_cond = 1'b1;
            ise_core_pkg::OP_MV2COP:
            begin
                wr_cond = 1'b1;
                wr_val  = s2_rs1;
            end
            ise_core_pkg::OP_CMOV:  wr_cond = (s2_crs2_data == '0); // Move on zero
            ise_core_pkg::OP_CMOVN: wr_cond = (s2_crs2_data != '0);
            ise_core_pkg::OP_BOP:
            begin
                wr_cond = 1'b1;
                wr_val  = bop_val;
            end
            ise_core_pkg::OP_LUI:
            begin
                wr_cond = 1'b1;
                wr_val  = {s2_imm16, s2_crd_data[15:0]};  // Keep low half
            end
            ise_core_pkg::OP_LLI:
            begin
                wr_cond = 1'b1;
                wr_val  = {s2_crd_data[31:16], s2_imm16}; // Keep high half
            end
            default: ; // NONE and INVALID write nothing
        endcase
    end

    assign cpr_wen   = s2_valid && wr_cond;
    assign cpr_waddr = s2_crd;
    assign cpr_wdata = wr_val;

    // Masks, all zero for invalid ops since no read flags are set
    assign rmask = ({ise_core_pkg::CPR_COUNT{s2_reads_crs1}} & (16'h1 << s2_crs1)) |
                   ({ise_core_pkg::CPR_COUNT{s2_reads_crs2}} & (16'h1 << s2_crs2)) |
                   ({ise_core_pkg::CPR_COUNT{s2_reads_crd}}  & (16'h1 << s2_crd));
    assign wmask = {ise_core_pkg::CPR_COUNT{cpr_wen}} & (16'h1 << s2_crd);

    // --------------------------------------------------
    // Result registers
    // --------------------------------------------------

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            result_valid <= 1'b0;
            rd_wen       <= 1'b0;
            cprs_read    <= '0;
            cprs_written <= '0;
        end
        else
        begin
            result_valid <= s2_valid;
            rd_wen       <= s2_valid && gpr_cond;
            cprs_read    <= s2_valid ? rmask : '0;
            cprs_written <= wmask;
        end
    end

    always_ff @(posedge g_clk)
    begin
        result  <= (s2_op == ise_core_pkg::OP_INVALID) ?
                   ise_core_pkg::RESULT_DECODE_EXCEPTION : ise_core_pkg::RESULT_SUCCESS;
        rd_addr <= s2_rd;
        rd_data <= s2_crs1_data; // Only mv2gpr raises rd_wen
    end

endmodule

// ==== verilog/ise_isa_pkg.sv ====
package ise_isa_pkg;

    // --------------------------------------------------
    // Major opcode
    // --------------------------------------------------

    localparam logic [6:0] ISE_OPCODE = 7'b0101011; // custom-1, bits 6..0

    // --------------------------------------------------
    // Field positions, given as the field LSB
    // --------------------------------------------------

    // Field widths come from the matching ise_core_pkg types
    localparam int FUNCT_LSB = 28; // Bits 31..28
    localparam int CRD_LSB   = 7;  // Bits 10..7
    localparam int RD_LSB    = 7;  // Bits 11..7, overlays CRD
    localparam int CRS1_LSB  = 15; // Bits 18..15
    localparam int CRS2_LSB  = 20; // Bits 23..20
    localparam int LUT4_LSB  = 24; // Bits 27..24
    localparam int IMM16_LSB = 12; // Bits 27..12, only for lui/lli

    // --------------------------------------------------
    // Function codes
    // --------------------------------------------------

    localparam logic [3:0] FUNCT_MV2GPR = 4'd0;
    localparam logic [3:0] FUNCT_MV2COP = 4'd1;
    localparam logic [3:0] FUNCT_CMOV   = 4'd2;
    localparam logic [3:0] FUNCT_CMOVN  = 4'd3;
    localparam logic [3:0] FUNCT_BOP    = 4'd4;
    localparam logic [3:0] FUNCT_LUI    = 4'd5;
    localparam logic [3:0] FUNCT_LLI    = 4'd6;
    // Codes 7..15 are reserved and decode as invalid

endpackage

// ==== verilog/ise_top.sv ====
`timescale 1ns/1ps

module ise_top (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    cop_insn_valid,   // Instruction strobe
    input  ise_core_pkg::word_t     cop_insn_enc,     // Encoded instruction
    input  ise_core_pkg::word_t     cop_rs1,          // GPR source operand
    output logic                    cop_result_valid, // Result strobe
    output ise_core_pkg::result_t   cop_result,
    output ise_core_pkg::cpr_mask_t cop_cprs_read,
    output ise_core_pkg::cpr_mask_t cop_cprs_written,
    output logic                    cop_rd_wen,
    output ise_core_pkg::gpr_idx_t  cop_rd_addr,
    output ise_core_pkg::word_t     cop_rd_data
);

    // --------------------------------------------------
    // Decode outputs, stage one
    // --------------------------------------------------

    ise_core_pkg::ise_op_t  dec_op;
    ise_core_pkg::cpr_idx_t dec_crd;
    ise_core_pkg::cpr_idx_t dec_crs1;
    ise_core_pkg::cpr_idx_t dec_crs2;
    ise_core_pkg::gpr_idx_t dec_rd;
    ise_core_pkg::lut_t     dec_lut4;
    ise_core_pkg::imm_t     dec_imm16;
    logic                   dec_reads_crs1;
    logic                   dec_reads_crs2;
    logic                   dec_reads_crd;

    // CPR read data
    ise_core_pkg::word_t    crs1_data;
    ise_core_pkg::word_t    crs2_data;
    ise_core_pkg::word_t    crd_data;

    // CPR write port, from stage two
    logic                   cpr_wen;
    ise_core_pkg::cpr_idx_t cpr_waddr;
    ise_core_pkg::word_t    cpr_wdata;

    ise_decoder decoder_i (
        .insn_valid (cop_insn_valid),
        .insn_enc   (cop_insn_enc),
        .op         (dec_op),
        .crd        (dec_crd),
        .crs1       (dec_crs1),
        .crs2       (dec_crs2),
        .rd         (dec_rd),
        .lut4       (dec_lut4),
        .imm16      (dec_imm16),
        .reads_crs1 (dec_reads_crs1),
        .reads_crs2 (dec_reads_crs2),
        .reads_crd  (dec_reads_crd)
    );

    ise_cpr_file cpr_file_i (
        .g_clk     (g_clk),
        .rd_addr_a (dec_crs1),
        .rd_addr_b (dec_crs2),
        .rd_addr_c (dec_crd),
        .rd_data_a (crs1_data),
        .rd_data_b (crs2_data),
        .rd_data_c (crd_data),
        .wen       (cpr_wen),
        .waddr     (cpr_waddr),
        .wdata     (cpr_wdata)
    );

    ise_exec_unit exec_unit_i (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .op           (dec_op),
        .crd          (dec_crd),
        .crs1         (dec_crs1),
        .crs2         (dec_crs2),
        .rd           (dec_rd),
        .lut4         (dec_lut4),
        .imm16        (dec_imm16),
        .reads_crs1   (dec_reads_crs1),
        .reads_crs2   (dec_reads_crs2),
        .reads_crd    (dec_reads_crd),
        .rs1_data     (cop_rs1),
        .crs1_data    (crs1_data),
        .crs2_data    (crs2_data),
        .crd_data     (crd_data),
        .cpr_wen      (cpr_wen),
        .cpr_waddr    (cpr_waddr),
        .cpr_wdata    (cpr_wdata),
        .result_valid (cop_result_valid),
        .result       (cop_result),
        .cprs_read    (cop_cprs_read),
        .cprs_written (cop_cprs_written),
        .rd_wen       (cop_rd_wen),
        .rd_addr      (cop_rd_addr),
        .rd_data      (cop_rd_data)
    );

endmodule
